// File: dv/dac_subsystem_checker.sv
`timescale 1ns/100ps
`include "dac_params.svh"

module dac_subsystem_checker
  import dac_pkg::*;
(
  input logic                       aclk,
  input logic                       arst_n,
  input logic                       wr_en,
  input logic                       grant_a,
  input logic                       grant_b,
  input logic                       rd_valid_a,
  input logic                       rd_valid_b,
  input logic                       dac_rst,
  input logic [`DAC_DATA_WIDTH-1:0] dac_dat
);

  int unsigned fail_count = 0;
  requester_e  granted;

  always_comb
  begin
    granted = grant_b ? REQ_B : (grant_a ? REQ_A : REQ_HOST);
  end

  one_grant: assert property (@(posedge aclk) disable iff (!arst_n) !(grant_a && grant_b))
  else
  begin
    fail_count++;
    $error("both players granted in one cycle");
  end

  host_first: assert property (@(posedge aclk) disable iff (!arst_n)
    wr_en |-> !(grant_a || grant_b))
  else
  begin
    fail_count++;
    $error("player granted during a host write");
  end

  valid_a: assert property (@(posedge aclk) disable iff (!arst_n)
    (granted == REQ_A) |=> rd_valid_a)
  else
  begin
    fail_count++;
    $error("grant_a not followed by rd_valid_a");
  end

  valid_b: assert property (@(posedge aclk) disable iff (!arst_n)
    (granted == REQ_B) |=> rd_valid_b)
  else
  begin
    fail_count++;
    $error("grant_b not followed by rd_valid_b");
  end

  // preponed values at posedge show channel b, at negedge channel a.
  quiet_b: assert property (@(posedge aclk) disable iff (!arst_n) dac_rst |-> dac_dat == '0)
  else
  begin
    fail_count++;
    $error("dac_dat nonzero in b half while dac_rst is high");
  end

  quiet_a: assert property (@(negedge aclk) disable iff (!arst_n) dac_rst |-> dac_dat == '0)
  else
  begin
    fail_count++;
    $error("dac_dat nonzero in a half while dac_rst is high");
  end

endmodule

bind dac_subsystem_top dac_subsystem_checker dac_subsystem_checker_inst
(
  .aclk       (aclk),
  .arst_n     (arst_n),
  .wr_en      (wr_en),
  .grant_a    (grant_a),
  .grant_b    (grant_b),
  .rd_valid_a (rd_valid_a),
  .rd_valid_b (rd_valid_b),
  .dac_rst    (dac_rst),
  .dac_dat    (dac_dat)
);

// File: dv/dac_subsystem_tb.sv
`timescale 1ns/100ps
`include "dac_params.svh"

module dac_subsystem_tb
  import dac_pkg::*;
();

  localparam int RESET_CYCLES = 16;
  localparam int RUN1_TICKS   = 64;
  localparam int RUN2_TICKS   = 32;
  localparam int RUN3_TICKS   = 24;
  localparam int WRITE_TICKS  = 20;
  localparam int CYCLE_LIMIT  =
    2 * (RESET_CYCLES + 256 + `DAC_TICK_DIV * (RUN1_TICKS + RUN2_TICKS + RUN3_TICKS + 6));

  logic                         aclk;
  logic                         arst_n;
  logic                         run;
  logic                         wr_en;
  logic [`TABLE_ADDR_WIDTH-1:0] wr_addr;
  sample_word_u                 wr_data;
  logic [`PHASE_WIDTH-1:0]      step_a;
  logic [`PHASE_WIDTH-1:0]      step_b;
  logic                         dac_clk;
  logic                         dac_rst;
  logic                         dac_sel;
  logic [`DAC_DATA_WIDTH-1:0]   dac_dat;

  logic [31:0]             lfsr_q = 32'ha348;
  logic [31:0]             table_m [256];  // model of the sample table.
  logic                    read_map [256];
  logic [`PHASE_WIDTH-1:0] phase_a;
  logic [`PHASE_WIDTH-1:0] phase_b;
  int unsigned             data_errs = 0;
  int unsigned             ctrl_errs = 0;
  int                      cycle_cnt = 0;

  dac_subsystem_top dac_subsystem_top_inst (
    .aclk    (aclk),
    .arst_n  (arst_n),
    .run     (run),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .step_a  (step_a),
    .step_b  (step_b),
    .dac_clk (dac_clk),
    .dac_rst (dac_rst),
    .dac_sel (dac_sel),
    .dac_dat (dac_dat)
  );

  initial
  begin
    aclk = 1'b0;
    forever #20 aclk = ~aclk;
  end

  always @(posedge aclk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt == CYCLE_LIMIT)
    begin
      $display("timeout: test did not finish within %0d cycles", CYCLE_LIMIT);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  function automatic logic next_bit();
    logic lsb;
    lsb    = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (lsb)
    begin
      lfsr_q = lfsr_q ^ 32'h8020_0003;
    end
    return lsb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[30:0], next_bit()};
    end
    return v;
  endfunction

  // table entry at phase[15:7], as offset binary.
  function automatic logic [`DAC_DATA_WIDTH-1:0] model_code(input logic [15:0] phase);
    logic [31:0] word;
    logic [15:0] s;
    word = table_m[phase[15:8]];
    s    = phase[7] ? word[31:16] : word[15:0];
    return s[13:0] + 14'h2000;  // shift by half scale.
  endfunction

  task automatic check_half(input logic [13:0] exp, input logic sel_exp, input logic rst_exp,
                            input string what);
    assert (dac_dat === exp)
    else
    begin
      data_errs++;
      $display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, what, exp, dac_dat);
    end
    assert (dac_sel === sel_exp && dac_clk === sel_exp && dac_rst === rst_exp)
    else
    begin
      ctrl_errs++;
      $display("CHECK FAILED at %0t ns: %s sel %b clk %b rst %b, expected %b %b %b", $time,
               what, dac_sel, dac_clk, dac_rst, sel_exp, sel_exp, rst_exp);
    end
  endtask

  // called 2 ns after an edge. a half then b half.
  task automatic check_pair(input int k);
    #8;
    check_half(model_code(phase_a), 1'b0, 1'b0, $sformatf("pair %0d channel a", k));
    #20;
    check_half(model_code(phase_b), 1'b1, 1'b0, $sformatf("pair %0d channel b", k));
  endtask

  task automatic check_idle();
    #8;
    check_half('0, 1'b0, 1'b1, "idle a half");
    #20;
    check_half('0, 1'b1, 1'b1, "idle b half");
  endtask

  task automatic write_word(input logic [`TABLE_ADDR_WIDTH-1:0] addr);
    wr_en          = 1'b1;
    wr_addr        = addr;
    wr_data.raw    = rand_bits(32);
    table_m[addr]  = wr_data.raw;
  endtask

  task automatic fill_table();
    for (int a = 0; a < 256; a++)
    begin
      @(posedge aclk);
      #2;
      write_word(`TABLE_ADDR_WIDTH'(a));
    end
    @(posedge aclk);
    #2;
    wr_en = 1'b0;
  endtask

  task automatic play_run(input int n_ticks, input int write_ticks, input bit check_all);
    int                           off;
    int                           n_wr;
    logic [`TABLE_ADDR_WIDTH-1:0] addr;
    step_a   = `PHASE_WIDTH'(rand_bits(16));
    step_b   = `PHASE_WIDTH'(rand_bits(16));
    phase_a  = '0;
    phase_b  = '0;
    read_map = '{default: 1'b0};
    for (int k = 0; k < n_ticks; k++)
    begin
      read_map[phase_a[15:8]] = 1'b1;  // words the players fetch this run.
      read_map[phase_b[15:8]] = 1'b1;
      phase_a += step_a;
      phase_b += step_b;
    end
    phase_a = '0;
    phase_b = '0;
    @(posedge aclk);
    #2;
    run = 1'b1;
    for (int k = 0; k < n_ticks; k++)
    begin
      off  = int'(rand_bits(2));
      n_wr = (k < write_ticks) ? int'(rand_bits(2) % 3 + 1) : 0;
      for (int c = 0; c < `DAC_TICK_DIV; c++)
      begin
        @(posedge aclk);  // edge t_k + c.
        #2;
        wr_en = 1'b0;
        if (c >= off && c < off + n_wr)
        begin
          addr = `TABLE_ADDR_WIDTH'(rand_bits(8));
          while (read_map[addr])
          begin
            addr = addr + 8'd1;
          end
          write_word(addr);
        end
        if (c == 4 && (check_all || k == n_ticks - 1))
        begin
          check_pair(k);
        end
      end
      phase_a += step_a;
      phase_b += step_b;
    end
  endtask

  task automatic stop_run();
    @(posedge aclk);
    #2;
    run = 1'b0;
    @(posedge aclk);
    #2;
    check_idle();
  endtask

  initial
  begin
    int unsigned total;
    arst_n  = 1'b0;
    run     = 1'b0;
    wr_en   = 1'b0;
    wr_addr = '0;
    wr_data = '0;
    step_a  = '0;
    step_b  = '0;
    phase_a = '0;
    phase_b = '0;
    repeat (RESET_CYCLES) @(posedge aclk);
    #2;
    arst_n = 1'b1;
    @(posedge aclk);
    #2;
    check_idle();
    fill_table();
    play_run(RUN1_TICKS, 0, 1'b1);
    stop_run();
    play_run(RUN2_TICKS, 0, 1'b1);  // phases restart at zero.
    stop_run();
    play_run(RUN3_TICKS, WRITE_TICKS, 1'b0);
    stop_run();
    total = data_errs + ctrl_errs + dac_subsystem_top_inst.dac_subsystem_checker_inst.fail_count;
    $display("errors: data %0d, control %0d, assertion %0d", data_errs, ctrl_errs,
             dac_subsystem_top_inst.dac_subsystem_checker_inst.fail_count);
    if (total == 0)
    begin
      $display("SIMULATION PASSED");
    end
    else
    begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: logic/dac_ddr_out.sv
`timescale 1ns/100ps
`include "dac_params.svh"

module dac_ddr_out
(
  input  logic                       aclk,
  input  logic                       arst_n,
  input  logic                       run,
  input  logic [`SAMPLE_WIDTH-1:0]   sample_a,
  input  logic [`SAMPLE_WIDTH-1:0]   sample_b,
  input  logic                       primed_a,
  input  logic                       primed_b,
  output logic                       dac_clk,
  output logic                       dac_rst,
  output logic                       dac_sel,
  output logic [`DAC_DATA_WIDTH-1:0] dac_dat
);

  localparam int DW = `DAC_DATA_WIDTH;

  logic          out_en;
  logic [DW-1:0] dat_a_q;
  logic [DW-1:0] dat_b_q;
  logic          rst_q;

  assign out_en = run & primed_a & primed_b;

  always_ff @(posedge aclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      dat_a_q <= '0;
      dat_b_q <= '0;
      rst_q   <= 1'b1;
    end
    else
    begin
      if (out_en)
      begin
        // two's complement to offset binary.
        dat_a_q <= {~sample_a[DW-1], sample_a[DW-2:0]};
        dat_b_q <= {~sample_b[DW-1], sample_b[DW-2:0]};
      end
      else
      begin
        dat_a_q <= '0;
        dat_b_q <= '0;
      end
      rst_q <= ~out_en;
    end
  end

  // behavioral DDR output, channel a in the high half.
  assign dac_dat = aclk ? dat_a_q : dat_b_q;
  assign dac_sel = ~aclk;
  assign dac_clk = ~aclk;
  assign dac_rst = rst_q;

endmodule

// File: logic/dac_params.svh
`ifndef DAC_PARAMS_SVH
`define DAC_PARAMS_SVH

// DAC converter width.
`define DAC_DATA_WIDTH 14

// one table sample; low 14 bits are two's complement.
`define SAMPLE_WIDTH 16

// table word address, two samples per word.
`define TABLE_ADDR_WIDTH 8
`define INDEX_WIDTH (`TABLE_ADDR_WIDTH + 1)

`define PHASE_WIDTH 16

// aclk cycles per output sample pair.
`define DAC_TICK_DIV 8

`endif

// File: logic/dac_pkg.sv
`include "dac_params.svh"

package dac_pkg;

  // one table word; host writes it whole, players pick a half.
  typedef union packed
  {
    logic [2*`SAMPLE_WIDTH-1:0]       raw;
    logic [1:0][`SAMPLE_WIDTH-1:0]    half;  // half[0] is the even sample.
  } sample_word_u;

  // who owns the table port in a given cycle.
  typedef enum logic [1:0]
  {
    REQ_HOST = 2'd0,
    REQ_A    = 2'd1,
    REQ_B    = 2'd2
  } requester_e;

endpackage

// File: logic/dac_subsystem_top.sv
`timescale 1ns/100ps
`include "dac_params.svh"

module dac_subsystem_top
  import dac_pkg::*;
(
  input  logic                         aclk,
  input  logic                         arst_n,
  input  logic                         run,
  input  logic                         wr_en,
  input  logic [`TABLE_ADDR_WIDTH-1:0] wr_addr,
  input  sample_word_u                 wr_data,
  input  logic [`PHASE_WIDTH-1:0]      step_a,
  input  logic [`PHASE_WIDTH-1:0]      step_b,
  output logic                         dac_clk,
  output logic                         dac_rst,
  output logic                         dac_sel,
  output logic [`DAC_DATA_WIDTH-1:0]   dac_dat
);

  localparam int TICK_CNT_W = $clog2(`DAC_TICK_DIV);

  logic [TICK_CNT_W-1:0]   tick_cnt_q;
  logic                    tick;
  logic                    run_q;
  logic [`PHASE_WIDTH-1:0] step_a_q;
  logic [`PHASE_WIDTH-1:0] step_b_q;

  logic                         req_a, req_b;
  logic [`INDEX_WIDTH-1:0]      index_a, index_b;
  logic                         grant_a, grant_b;
  logic                         rd_valid_a, rd_valid_b;
  sample_word_u                 rd_word;
  logic                         ram_we;
  logic [`TABLE_ADDR_WIDTH-1:0] ram_addr;
  sample_word_u                 ram_wdata, ram_rdata;
  logic [`SAMPLE_WIDTH-1:0]     sample_a, sample_b;
  logic                         primed_a, primed_b;

  // first tick in the first run cycle.
  assign tick = run & (tick_cnt_q == '0);

  always_ff @(posedge aclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      tick_cnt_q <= '0;
      run_q      <= 1'b0;
    end
    else
    begin
      run_q <= run;
      if (!run || tick_cnt_q == TICK_CNT_W'(`DAC_TICK_DIV - 1))
      begin
        tick_cnt_q <= '0;
      end
      else
      begin
        tick_cnt_q <= tick_cnt_q + 1'b1;
      end
    end
  end

  // steps are latched on the run rising edge.
  always_ff @(posedge aclk)
  begin
    if (run && !run_q)
    begin
      step_a_q <= step_a;
      step_b_q <= step_b;
    end
  end

  sample_ram sample_ram_inst (
    .aclk  (aclk),
    .we    (ram_we),
    .addr  (ram_addr),
    .wdata (ram_wdata),
    .rdata (ram_rdata)
  );

  sample_arbiter sample_arbiter_inst (
    .aclk       (aclk),
    .arst_n     (arst_n),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .req_a      (req_a),
    .req_b      (req_b),
    .index_a    (index_a),
    .index_b    (index_b),
    .grant_a    (grant_a),
    .grant_b    (grant_b),
    .rd_valid_a (rd_valid_a),
    .rd_valid_b (rd_valid_b),
    .rd_word    (rd_word),
    .ram_we     (ram_we),
    .ram_addr   (ram_addr),
    .ram_wdata  (ram_wdata),
    .ram_rdata  (ram_rdata)
  );

  wave_player wave_player_a_inst (
    .aclk         (aclk),
    .arst_n       (arst_n),
    .run          (run),
    .tick         (tick),
    .step         (step_a_q),
    .req          (req_a),
    .sample_index (index_a),
    .grant        (grant_a),
    .rd_valid     (rd_valid_a),
    .rd_word      (rd_word),
    .sample       (sample_a),
    .primed       (primed_a)
  );

  wave_player wave_player_b_inst (
    .aclk         (aclk),
    .arst_n       (arst_n),
    .run          (run),
    .tick         (tick),
    .step         (step_b_q),
    .req          (req_b),
    .sample_index (index_b),
    .grant        (grant_b),
    .rd_valid     (rd_valid_b),
    .rd_word      (rd_word),
    .sample       (sample_b),
    .primed       (primed_b)
  );

  dac_ddr_out dac_ddr_out_inst (
    .aclk     (aclk),
    .arst_n   (arst_n),
    .run      (run),
    .sample_a (sample_a),
    .sample_b (sample_b),
    .primed_a (primed_a),
    .primed_b (primed_b),
    .dac_clk  (dac_clk),
    .dac_rst  (dac_rst),
    .dac_sel  (dac_sel),
    .dac_dat  (dac_dat)
  );

endmodule

// File: logic/sample_arbiter.sv
`timescale 1ns/100ps
`include "dac_params.svh"

module sample_arbiter
  import dac_pkg::*;
(
  input  logic                         aclk,
  input  logic                         arst_n,
  input  logic                         wr_en,
  input  logic [`TABLE_ADDR_WIDTH-1:0] wr_addr,
  input  sample_word_u                 wr_data,
  input  logic                         req_a,
  input  logic                         req_b,
  input  logic [`INDEX_WIDTH-1:0]      index_a,
  input  logic [`INDEX_WIDTH-1:0]      index_b,
  output logic                         grant_a,
  output logic                         grant_b,
  output logic                         rd_valid_a,
  output logic                         rd_valid_b,
  output sample_word_u                 rd_word,
  output logic                         ram_we,
  output logic [`TABLE_ADDR_WIDTH-1:0] ram_addr,
  output sample_word_u                 ram_wdata,
  input  sample_word_u                 ram_rdata
);

  logic       rr_b_q;     // set when player b has priority.
  logic       owner_vld_q;
  requester_e owner_q;
  requester_e winner;

  // host write always wins the port.
  assign grant_a = ~wr_en & req_a & (~req_b | ~rr_b_q);
  assign grant_b = ~wr_en & req_b & (~req_a | rr_b_q);

  always_comb
  begin
    ram_we    = wr_en;
    ram_wdata = wr_data;
    if (wr_en)
    begin
      winner   = REQ_HOST;
      ram_addr = wr_addr;
    end
    else if (grant_b)
    begin
      winner   = REQ_B;
      ram_addr = index_b[`INDEX_WIDTH-1:1];
    end
    else
    begin
      winner   = REQ_A;
      ram_addr = index_a[`INDEX_WIDTH-1:1];
    end
  end

  always_ff @(posedge aclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      rr_b_q      <= 1'b0;
      owner_vld_q <= 1'b0;
      owner_q     <= REQ_HOST;
    end
    else
    begin
      if (grant_a || grant_b)
      begin
        rr_b_q <= grant_a;  // last winner yields.
      end
      owner_vld_q <= grant_a | grant_b;
      owner_q     <= winner;
    end
  end

  // ram output lines up with the registered owner.
  assign rd_word    = ram_rdata;
  assign rd_valid_a = owner_vld_q && (owner_q == REQ_A);
  assign rd_valid_b = owner_vld_q && (owner_q == REQ_B);

endmodule

// File: logic/sample_ram.sv
`timescale 1ns/100ps
`include "dac_params.svh"

module sample_ram
  import dac_pkg::*;
(
  input  logic                         aclk,
  input  logic                         we,
  input  logic [`TABLE_ADDR_WIDTH-1:0] addr,
  input  sample_word_u                 wdata,
  output sample_word_u                 rdata
);

  localparam int DEPTH = 1 << `TABLE_ADDR_WIDTH;

  sample_word_u mem [DEPTH];

  // read data holds its last value across a write.
  always_ff @(posedge aclk)
  begin
    if (we)
    begin
      mem[addr] <= wdata;
    end
    else
    begin
      rdata <= mem[addr];
    end
  end

endmodule

// File: logic/wave_player.sv
`timescale 1ns/100ps
`include "dac_params.svh"

module wave_player
  import dac_pkg::*;
(
  input  logic                     aclk,
  input  logic                     arst_n,
  input  logic                     run,
  input  logic                     tick,
  input  logic [`PHASE_WIDTH-1:0]  step,
  output logic                     req,
  output logic [`INDEX_WIDTH-1:0]  sample_index,
  input  logic                     grant,
  input  logic                     rd_valid,
  input  sample_word_u             rd_word,
  output logic [`SAMPLE_WIDTH-1:0] sample,
  output logic                     primed
);

  logic [`PHASE_WIDTH-1:0] phase_q;
  logic                    half_sel_q;

  assign sample_index = phase_q[`PHASE_WIDTH-1 -: `INDEX_WIDTH];

  always_ff @(posedge aclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      req     <= 1'b0;
      phase_q <= '0;
      primed  <= 1'b0;
    end
    else if (!run)
    begin
      req     <= 1'b0;
      phase_q <= '0;
      primed  <= 1'b0;
    end
    else
    begin
      // a new tick re-arms even if the old fetch is served now.
      if (tick)
      begin
        req <= 1'b1;
      end
      else if (grant)
      begin
        req <= 1'b0;
      end

      if (grant)
      begin
        phase_q <= phase_q + step;  // advance on grant, never lose a step.
      end

      if (rd_valid)
      begin
        primed <= 1'b1;
      end
    end
  end

  always_ff @(posedge aclk)
  begin
    if (grant)
    begin
      half_sel_q <= sample_index[0];
    end
    if (rd_valid)
    begin
      sample <= rd_word.half[half_sel_q];
    end
  end

endmodule

// File: verilog.f
+incdir+logic
logic/dac_pkg.sv
logic/sample_ram.sv
logic/sample_arbiter.sv
logic/wave_player.sv
logic/dac_ddr_out.sv
logic/dac_subsystem_top.sv
dv/dac_subsystem_checker.sv
dv/dac_subsystem_tb.sv
